/* compile.f */
+incdir+.
mem_pkg.sv
axi_lite_if.sv
axi_read_arbiter.sv
axi_sram.sv
mem_subsys_top.sv
mem_subsys_properties.sv
mem_subsys_tb.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - include_dirs:
      - .
    files:
      - mem_pkg.sv
      - axi_lite_if.sv
      - axi_read_arbiter.sv
      - axi_sram.sv
      - mem_subsys_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - mem_subsys_properties.sv
      - mem_subsys_tb.sv

/* mem_subsys_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

// random traffic on both masters against a reference memory model
module mem_subsys_tb
	import mem_pkg::*;
();

	localparam int WORDS    = `MEM_WORDS;
	localparam int HALF     = WORDS / 2;
	localparam int N_STRB   = 48;
	localparam int N_FETCH  = 64;
	localparam int N_UPPER  = 32;
	localparam int N_SHARED = 64;
	localparam int N_OOB    = 8;
	// preload, strobe pairs, fetch phase, shared phase, oob pairs, sweep, stall pair, latency
	localparam int N_TOTAL = HALF + 2 * N_STRB + N_FETCH + N_UPPER + 2 * N_SHARED
		+ 2 * N_OOB + HALF + N_UPPER + 3;
	localparam int CYCLE_LIMIT = 20 * N_TOTAL + 200;

	logic                   clk;
	logic                   rst;
	logic                   fetch_arvalid, fetch_rready, fetch_arready, fetch_rvalid;
	logic [`MEM_ADDR_W-1:0] fetch_araddr;
	logic [`MEM_DATA_W-1:0] fetch_rdata;
	resp_e                  fetch_rresp;
	logic                   data_arvalid, data_rready, data_arready, data_rvalid;
	logic [`MEM_ADDR_W-1:0] data_araddr, data_awaddr;
	logic [`MEM_DATA_W-1:0] data_rdata, data_wdata;
	resp_e                  data_rresp, data_bresp;
	logic                   data_awvalid, data_wvalid, data_bready;
	logic                   data_awready, data_wready, data_bvalid;
	logic [`MEM_STRB_W-1:0] data_wstrb;

	// model words by word index
	// only written words exist
	logic [`MEM_DATA_W-1:0] model_mem [int];
	int errors;
	int checks;
	int cycles;
	// set while a master has a read accepted but not yet returned
	bit fetch_pending;
	bit data_pending;

	mem_subsys_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, a transfer never completed", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// R beats must only reach the master that asked
	always @(negedge clk) begin
		if (!rst && fetch_rvalid && !fetch_pending) begin
			errors++;
			$display("fetch port saw rvalid with no read outstanding");
		end
		if (!rst && data_rvalid && !data_pending) begin
			errors++;
			$display("data port saw rvalid with no read outstanding");
		end
	end

	function automatic bit in_range(input logic [`MEM_ADDR_W-1:0] addr);
		return addr < WORDS * 8;
	endfunction

	// strobe merge
	// out of range writes are dropped
	function automatic void model_write(input logic [`MEM_ADDR_W-1:0] addr,
			input logic [`MEM_DATA_W-1:0] wd, input logic [`MEM_STRB_W-1:0] strb);
		logic [`MEM_DATA_W-1:0] word;
		if (in_range(addr)) begin
			word = model_mem.exists(addr[31:3]) ? model_mem[addr[31:3]] : '0;
			for (int b = 0; b < `MEM_STRB_W; b++) begin
				if (strb[b]) word[b*8 +: 8] = wd[b*8 +: 8];
			end
			model_mem[addr[31:3]] = word;
		end
	endfunction

	function automatic logic [`MEM_DATA_W-1:0] model_read(input logic [`MEM_ADDR_W-1:0] addr);
		if (in_range(addr) && model_mem.exists(addr[31:3])) return model_mem[addr[31:3]];
		return '0;
	endfunction

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic fetch_read(input logic [`MEM_ADDR_W-1:0] addr, input int stall,
			input string name);
		logic [`MEM_DATA_W-1:0] exp_data;
		resp_e exp_resp;
		@(negedge clk);
		fetch_arvalid = 1'b1;
		fetch_araddr  = addr;
		do @(posedge clk); while (!fetch_arready);
		exp_data      = model_read(addr);
		exp_resp      = in_range(addr) ? resp_okay : resp_slverr;
		fetch_pending = 1'b1;
		@(negedge clk);
		fetch_arvalid = 1'b0;
		// hold off rready a few cycles
		repeat (stall) @(negedge clk);
		fetch_rready = 1'b1;
		do @(posedge clk); while (!fetch_rvalid);
		fetch_pending = 1'b0;
		compare({name, " rdata"}, exp_data, fetch_rdata);
		compare({name, " rresp"}, 64'(exp_resp), 64'(fetch_rresp));
		@(negedge clk);
		fetch_rready = 1'b0;
	endtask

	task automatic data_read(input logic [`MEM_ADDR_W-1:0] addr, input int stall,
			input string name);
		logic [`MEM_DATA_W-1:0] exp_data;
		resp_e exp_resp;
		@(negedge clk);
		data_arvalid = 1'b1;
		data_araddr  = addr;
		do @(posedge clk); while (!data_arready);
		exp_data     = model_read(addr);
		exp_resp     = in_range(addr) ? resp_okay : resp_slverr;
		data_pending = 1'b1;
		@(negedge clk);
		data_arvalid = 1'b0;
		repeat (stall) @(negedge clk);
		data_rready = 1'b1;
		do @(posedge clk); while (!data_rvalid);
		data_pending = 1'b0;
		compare({name, " rdata"}, exp_data, data_rdata);
		compare({name, " rresp"}, 64'(exp_resp), 64'(data_rresp));
		@(negedge clk);
		data_rready = 1'b0;
	endtask

	task automatic data_write(input logic [`MEM_ADDR_W-1:0] addr,
			input logic [`MEM_DATA_W-1:0] wd, input logic [`MEM_STRB_W-1:0] strb,
			input int stall, input string name);
		resp_e exp_resp;
		@(negedge clk);
		data_awvalid = 1'b1;
		data_awaddr  = addr;
		data_wvalid  = 1'b1;
		data_wdata   = wd;
		data_wstrb   = strb;
		do @(posedge clk); while (!(data_awready && data_wready));
		model_write(addr, wd, strb);
		exp_resp = in_range(addr) ? resp_okay : resp_slverr;
		@(negedge clk);
		data_awvalid = 1'b0;
		data_wvalid  = 1'b0;
		// B slot full and bready low, so no new pair may be taken
		repeat (stall) begin
			@(posedge clk);
			checks++;
			if (!data_bvalid || data_awready || data_wready) begin
				errors++;
				$display("%s: bvalid dropped or awready or wready rose while bready was low",
					name);
			end
			@(negedge clk);
		end
		data_bready = 1'b1;
		do @(posedge clk); while (!data_bvalid);
		compare({name, " bresp"}, 64'(exp_resp), 64'(data_bresp));
		@(negedge clk);
		data_bready = 1'b0;
	endtask

	initial begin
		logic [`MEM_ADDR_W-1:0] addr;
		void'($urandom(32'hba0a_c46d));
		errors        = 0;
		checks        = 0;
		cycles        = 0;
		fetch_pending = 1'b0;
		data_pending  = 1'b0;
		rst           = 1'b1;
		fetch_arvalid = 1'b0;
		fetch_araddr  = '0;
		fetch_rready  = 1'b0;
		data_arvalid  = 1'b0;
		data_araddr   = '0;
		data_rready   = 1'b0;
		data_awvalid  = 1'b0;
		data_awaddr   = '0;
		data_wvalid   = 1'b0;
		data_wdata    = '0;
		data_wstrb    = '0;
		data_bready   = 1'b0;
		// two reset edges, release on the falling edge after them
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// full words first so later strobed merges start from known bytes
		for (int i = 0; i < HALF; i++) begin
			data_write(i * 8, {$urandom, $urandom}, 8'hff, 0, "preload");
		end

		// strobed writes each read back on the data port
		for (int i = 0; i < N_STRB; i++) begin
			addr = $urandom_range(HALF * 8 - 1, 0);
			data_write(addr, {$urandom, $urandom}, 8'($urandom), $urandom_range(3, 0),
				"strobed write");
			data_read(addr, $urandom_range(3, 0), "strobed readback");
		end

		// fetch reads the lower half while data writes the upper half
		fork
			for (int i = 0; i < N_FETCH; i++) begin
				fetch_read($urandom_range(HALF * 8 - 1, 0), $urandom_range(3, 0), "fetch read");
			end
			for (int i = 0; i < N_UPPER; i++) begin
				data_write($urandom_range(WORDS * 8 - 1, HALF * 8), {$urandom, $urandom}, 8'hff,
					$urandom_range(3, 0), "upper write");
			end
		join

		// both masters contend for the read channel
		fork
			for (int i = 0; i < N_SHARED; i++) begin
				fetch_read($urandom_range(HALF * 8 - 1, 0), $urandom_range(3, 0), "shared fetch");
			end
			for (int i = 0; i < N_SHARED; i++) begin
				data_read($urandom_range(HALF * 8 - 1, 0), $urandom_range(3, 0), "shared data");
			end
		join

		// addresses beyond the array whose low bits alias real words
		for (int i = 0; i < N_OOB; i++) begin
			addr = (i + 1) * WORDS * 8 + $urandom_range(WORDS * 8 - 1, 0);
			data_write(addr, {$urandom, $urandom}, 8'hff, 0, "oob write");
			data_read(addr, $urandom_range(3, 0), "oob read");
		end
		foreach (model_mem[k]) begin
			data_read(k * 8, $urandom_range(3, 0), "sweep read");
		end

		// long B stall then a write straight after
		data_write(32'h10, {$urandom, $urandom}, 8'hff, 6, "bready stall");
		data_write(32'h18, {$urandom, $urandom}, 8'h0f, 0, "write after stall");

		// idle channel with rready already high
		@(negedge clk);
		fetch_arvalid = 1'b1;
		fetch_araddr  = 32'h40;
		fetch_rready  = 1'b1;
		do @(posedge clk); while (!fetch_arready);
		fetch_pending = 1'b1;
		@(negedge clk);
		fetch_arvalid = 1'b0;
		checks++;
		if (!fetch_rvalid) begin
			errors++;
			$display("rvalid not high one cycle after the fetch AR handshake");
		end
		@(posedge clk);
		fetch_pending = 1'b0;
		compare("latency rdata", model_read(32'h40), fetch_rdata);
		@(negedge clk);
		fetch_rready = 1'b0;

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* mem_subsys_properties.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

// handshake rules on the sram response channels
module mem_subsys_properties
	import mem_pkg::*;
(
	input logic                   clk,
	input logic                   rst,
	input logic                   rvalid,
	input logic                   rready,
	input logic [`MEM_DATA_W-1:0] rdata,
	input logic                   bvalid,
	input logic                   bready,
	input resp_e                  bresp
);

	// stalled R beat stays up
	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	// and keeps its data
	a_rdata_stable: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> $stable(rdata))
		else $error("rdata changed while the R beat was stalled");

	a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	a_bresp_stable: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> $stable(bresp))
		else $error("bresp changed while the B beat was stalled");

	// both response slots empty out of reset
	a_reset_idle: assert property (@(posedge clk) rst |=> !rvalid && !bvalid)
		else $error("response valid high in the cycle after reset");

endmodule

bind axi_sram mem_subsys_properties u_props (
	.clk    (clk),
	.rst    (rst),
	.rvalid (rd.rvalid),
	.rready (rd.rready),
	.rdata  (rd.rdata),
	.bvalid (wr.bvalid),
	.bready (wr.bready),
	.bresp  (wr.bresp)
);

`default_nettype wire

/* mem_subsys_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

// memory subsystem top
// fetch and data read through the arbiter, data writes go direct
module mem_subsys_top
	import mem_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,

	// instruction fetch, read only
	input  logic                   fetch_arvalid,
	input  logic [`MEM_ADDR_W-1:0] fetch_araddr,
	input  logic                   fetch_rready,
	output logic                   fetch_arready,
	output logic                   fetch_rvalid,
	output logic [`MEM_DATA_W-1:0] fetch_rdata,
	output resp_e                  fetch_rresp,

	// data port, read channels
	input  logic                   data_arvalid,
	input  logic [`MEM_ADDR_W-1:0] data_araddr,
	input  logic                   data_rready,
	output logic                   data_arready,
	output logic                   data_rvalid,
	output logic [`MEM_DATA_W-1:0] data_rdata,
	output resp_e                  data_rresp,

	// data port, write channels
	input  logic                   data_awvalid,
	input  logic [`MEM_ADDR_W-1:0] data_awaddr,
	input  logic                   data_wvalid,
	input  logic [`MEM_DATA_W-1:0] data_wdata,
	input  logic [`MEM_STRB_W-1:0] data_wstrb,
	input  logic                   data_bready,
	output logic                   data_awready,
	output logic                   data_wready,
	output logic                   data_bvalid,
	output resp_e                  data_bresp
);

	axi_rd_if u_fetch_rd ();
	axi_rd_if u_data_rd ();
	// arbiter to sram
	axi_rd_if u_sram_rd ();
	axi_wr_if u_data_wr ();

	// fetch ports onto its read interface
	assign u_fetch_rd.arvalid = fetch_arvalid;
	assign u_fetch_rd.araddr  = fetch_araddr;
	assign u_fetch_rd.rready  = fetch_rready;
	assign fetch_arready      = u_fetch_rd.arready;
	assign fetch_rvalid       = u_fetch_rd.rvalid;
	assign fetch_rdata        = u_fetch_rd.rdata;
	assign fetch_rresp        = u_fetch_rd.rresp;

	// data read ports
	assign u_data_rd.arvalid = data_arvalid;
	assign u_data_rd.araddr  = data_araddr;
	assign u_data_rd.rready  = data_rready;
	assign data_arready      = u_data_rd.arready;
	assign data_rvalid       = u_data_rd.rvalid;
	assign data_rdata        = u_data_rd.rdata;
	assign data_rresp        = u_data_rd.rresp;

	// data write ports, no arbitration needed
	assign u_data_wr.awvalid = data_awvalid;
	assign u_data_wr.awaddr  = data_awaddr;
	assign u_data_wr.wvalid  = data_wvalid;
	assign u_data_wr.wdata   = data_wdata;
	assign u_data_wr.wstrb   = data_wstrb;
	assign u_data_wr.bready  = data_bready;
	assign data_awready      = u_data_wr.awready;
	assign data_wready       = u_data_wr.wready;
	assign data_bvalid       = u_data_wr.bvalid;
	assign data_bresp        = u_data_wr.bresp;

	axi_read_arbiter u_arbiter (
		.clk   (clk),
		.rst   (rst),
		.fetch (u_fetch_rd.slave),
		.data  (u_data_rd.slave),
		.mem   (u_sram_rd.master)
	);

	axi_sram u_sram (
		.clk (clk),
		.rst (rst),
		.rd  (u_sram_rd.slave),
		.wr  (u_data_wr.slave)
	);

endmodule

`default_nettype wire

/* axi_sram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

// on-chip sram slave with AXI-lite style read and write channels
// one cycle read latency, byte strobed writes, slverr above the array
module axi_sram
	import mem_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	axi_rd_if.slave rd,
	axi_wr_if.slave wr
);

	// byte offset inside a word, then word index
	localparam int OFF_W = $clog2(`MEM_STRB_W);
	localparam int IDX_W = $clog2(`MEM_WORDS);

	// first byte address past the array
	// one bit wider than the bus so the compare cannot wrap
	localparam logic [`MEM_ADDR_W:0] ADDR_LIMIT = `MEM_WORDS * `MEM_STRB_W;

	// storage, contents undefined until written
	logic [`MEM_DATA_W-1:0] mem [0:`MEM_WORDS-1];

	logic             ar_hs;
	logic             wr_hs;
	logic             rd_in_range;
	logic             wr_in_range;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;

	// address decode
	// low OFF_W address bits are ignored, accesses are whole words
	assign rd_idx      = rd.araddr[OFF_W +: IDX_W];
	assign wr_idx      = wr.awaddr[OFF_W +: IDX_W];
	assign rd_in_range = ({1'b0, rd.araddr} < ADDR_LIMIT);
	assign wr_in_range = ({1'b0, wr.awaddr} < ADDR_LIMIT);

	// read side
	// take a new address when the R slot is empty or drains this cycle
	assign rd.arready = !rd.rvalid || rd.rready;
	assign ar_hs      = rd.arvalid && rd.arready;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd.rvalid <= 1'b0;
			rd.rresp  <= resp_okay;
		end else if (ar_hs) begin
			rd.rvalid <= 1'b1;
			rd.rresp  <= rd_in_range ? resp_okay : resp_slverr;
		end else if (rd.rvalid && rd.rready) begin
			rd.rvalid <= 1'b0;
		end
	end

	// read data, held while rvalid waits for rready
	// nonblocking update so a same-cycle write still returns old data
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			if (rd_in_range) begin
				rd.rdata <= mem[rd_idx];
			end else begin
				rd.rdata <= '0;
			end
		end
	end

	// write side
	// both readys follow the B slot, the master offers AW and W together
	// and only the pair is acted on
	assign wr.awready = !wr.bvalid || wr.bready;
	assign wr.wready  = !wr.bvalid || wr.bready;
	assign wr_hs      = wr.awvalid && wr.awready && wr.wvalid && wr.wready;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr.bvalid <= 1'b0;
			wr.bresp  <= resp_okay;
		end else if (wr_hs) begin
			wr.bvalid <= 1'b1;
			wr.bresp  <= wr_in_range ? resp_okay : resp_slverr;
		end else if (wr.bvalid && wr.bready) begin
			wr.bvalid <= 1'b0;
		end
	end

	// byte merge into the array
	// out of range writes leave memory alone
	always_ff @(posedge clk) begin
		if (wr_hs && wr_in_range) begin
			for (int b = 0; b < `MEM_STRB_W; b++) begin
				if (wr.wstrb[b]) begin
					mem[wr_idx][b*8 +: 8] <= wr.wdata[b*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* axi_read_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

// shares one read channel between the fetch and data masters
// AR side is purely combinational, R side follows the stored owner
module axi_read_arbiter
	import mem_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	axi_rd_if.slave  fetch,
	axi_rd_if.slave  data,
	axi_rd_if.master mem
);

	// winner of the most recent AR handshake
	grant_e last_win;
	// master the outstanding read belongs to
	grant_e owner;
	// requester picked this cycle
	grant_e sel;

	logic ar_hs;

	// round-robin pick
	// on contention the master that lost last time goes first
	always_comb begin
		if (fetch.arvalid && data.arvalid) begin
			if (last_win == grant_data) begin
				sel = grant_fetch;
			end else begin
				sel = grant_data;
			end
		end else if (fetch.arvalid) begin
			sel = grant_fetch;
		end else begin
			// data alone, or nobody asking
			sel = grant_data;
		end
	end

	// AR request towards the sram
	assign mem.arvalid = fetch.arvalid || data.arvalid;

	always_comb begin
		case (sel)
			grant_fetch: mem.araddr = fetch.araddr;
			default:     mem.araddr = data.araddr;
		endcase
	end

	// arready only back to the selected master
	// the other one keeps its valid up and waits
	assign fetch.arready = mem.arready && (sel == grant_fetch);
	assign data.arready  = mem.arready && (sel == grant_data);

	assign ar_hs = mem.arvalid && mem.arready;

	// last winner, reset so that data wins the first tie
	always_ff @(posedge clk) begin
		if (rst) begin
			last_win <= grant_fetch;
		end else if (ar_hs) begin
			last_win <= sel;
		end
	end

	// owner of the read in flight
	// sram arready drops while an R beat is stalled, so at most one read
	// is ever unfinished and a single owner register is enough
	always_ff @(posedge clk) begin
		if (rst) begin
			owner <= grant_fetch;
		end else if (ar_hs) begin
			owner <= sel;
		end
	end

	// R valid only to the owner
	assign fetch.rvalid = mem.rvalid && (owner == grant_fetch);
	assign data.rvalid  = mem.rvalid && (owner == grant_data);

	// payload goes to both, rvalid qualifies it
	assign fetch.rdata = mem.rdata;
	assign fetch.rresp = mem.rresp;
	assign data.rdata  = mem.rdata;
	assign data.rresp  = mem.rresp;

	// rready taken from the owner only
	// an R handshake and a new AR handshake can share an edge,
	// the old owner's rready is used since owner updates after it
	always_comb begin
		case (owner)
			grant_fetch: mem.rready = fetch.rready;
			default:     mem.rready = data.rready;
		endcase
	end

endmodule

`default_nettype wire

/* axi_lite_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

// read channel group, AR and R
// the fetch port only ever needs this one
interface axi_rd_if
	import mem_pkg::*;
();

	// address request
	logic                   arvalid;
	logic [`MEM_ADDR_W-1:0] araddr;
	logic                   arready;

	// read data return
	logic                   rvalid;
	logic [`MEM_DATA_W-1:0] rdata;
	resp_e                  rresp;
	logic                   rready;

	modport master (
		output arvalid, araddr, rready,
		input  arready, rvalid, rdata, rresp
	);

	modport slave (
		input  arvalid, araddr, rready,
		output arready, rvalid, rdata, rresp
	);

endinterface

// write channel group, AW, W and B
// address and data are expected to be offered together
interface axi_wr_if
	import mem_pkg::*;
();

	logic                   awvalid;
	logic [`MEM_ADDR_W-1:0] awaddr;
	logic                   awready;

	logic                   wvalid;
	logic [`MEM_DATA_W-1:0] wdata;
	logic [`MEM_STRB_W-1:0] wstrb;
	logic                   wready;

	// write response
	logic                   bvalid;
	resp_e                  bresp;
	logic                   bready;

	modport master (
		output awvalid, awaddr, wvalid, wdata, wstrb, bready,
		input  awready, wready, bvalid, bresp
	);

	modport slave (
		input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
		output awready, wready, bvalid, bresp
	);

endinterface

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none

// shared types for the memory subsystem
// used by the sram slave, the read arbiter, both bus interfaces
// and the testbench reference model
package mem_pkg;

	// response code on the R and B channels
	// encoding follows the usual AXI values, so 2'b01 and 2'b11 are never produced
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		// address beyond the array
		resp_slverr = 2'b10
	} resp_e;

	// owner of the shared read channel
	// arbiter keeps both its last winner and the current R owner in this type
	typedef enum logic {
		// instruction fetch port, read only
		grant_fetch = 1'b0,
		// load/store port
		grant_data  = 1'b1
	} grant_e;

endpackage

`default_nettype wire

/* mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// byte address width on every AR and AW channel
`define MEM_ADDR_W 32

// data width of the R and W channels
`define MEM_DATA_W 64

// sram depth in MEM_DATA_W wide words
// any power of two works, the index width follows from it
`define MEM_WORDS 1024

// one strobe bit per data byte
`define MEM_STRB_W (`MEM_DATA_W / 8)

`endif
